// ==== ooo_pkg.sv ====
`default_nettype none

package ooo_pkg;

    localparam int ARCH_REGS = 8;
    localparam int REG_IDX_W = 3;
    localparam int ROB_DEPTH = 8;
    localparam int ROB_TAG_W = 3;
    localparam int DATA_W    = 32;
    localparam int PC_W      = 32;
    localparam int UOP_W     = 16;

    // op field, bits 15 to 13 in both formats
    localparam logic [2:0] OP_NOP  = 3'd0;
    localparam logic [2:0] OP_ADD  = 3'd1;
    localparam logic [2:0] OP_SUB  = 3'd2;
    localparam logic [2:0] OP_ADDI = 3'd3;
    localparam logic [2:0] OP_AND  = 3'd4;
    localparam logic [2:0] OP_XOR  = 3'd5;
    localparam logic [2:0] OP_BEQ  = 3'd6;

    // one micro-op word, read as alu or branch format
    typedef union packed {
        struct packed {
            logic [2:0]           op;
            logic [REG_IDX_W-1:0] rd;
            logic [REG_IDX_W-1:0] rs1;
            logic [REG_IDX_W-1:0] rs2;
            logic [3:0]           imm4;
        } alu;
        struct packed {
            logic [2:0]           op;
            logic [REG_IDX_W-1:0] rs1;
            logic [REG_IDX_W-1:0] rs2;
            logic                 pred_taken;
            // signed, counted in words
            logic [5:0]           offset;
        } br;
    } uop_t;

endpackage

`default_nettype wire

// ==== rename_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_table (
    input  wire                            clk_in,
    input  wire                            rst_n,
    input  wire                            disp_valid,
    input  wire  [ooo_pkg::UOP_W-1:0]      disp_uop,
    input  wire                            flush,
    input  wire                            commit_we,
    input  wire  [ooo_pkg::REG_IDX_W-1:0]  commit_rd,
    input  wire  [ooo_pkg::DATA_W-1:0]     commit_val,
    input  wire  [ooo_pkg::ROB_TAG_W-1:0]  commit_tag,
    input  wire  [ooo_pkg::ROB_TAG_W-1:0]  alloc_tag,
    input  wire                            q1_ready,
    input  wire  [ooo_pkg::DATA_W-1:0]     q1_val,
    input  wire                            q2_ready,
    input  wire  [ooo_pkg::DATA_W-1:0]     q2_val,
    output logic [ooo_pkg::ROB_TAG_W-1:0]  rob_q1_tag,
    output logic [ooo_pkg::ROB_TAG_W-1:0]  rob_q2_tag,
    output logic [ooo_pkg::DATA_W-1:0]     src1_val,
    output logic [ooo_pkg::ROB_TAG_W-1:0]  src1_tag,
    output logic                           src1_rdy,
    output logic [ooo_pkg::DATA_W-1:0]     src2_val,
    output logic [ooo_pkg::ROB_TAG_W-1:0]  src2_tag,
    output logic                           src2_rdy
);

    logic [ooo_pkg::DATA_W-1:0]    regs [ooo_pkg::ARCH_REGS];
    logic [ooo_pkg::ROB_TAG_W-1:0] tag_tbl [ooo_pkg::ARCH_REGS];
    logic [ooo_pkg::ARCH_REGS-1:0] busy;
    ooo_pkg::uop_t                 uop;
    logic [ooo_pkg::REG_IDX_W-1:0] rs1;
    logic [ooo_pkg::REG_IDX_W-1:0] rs2;
    logic                          is_br;
    logic                          writes_rd;

    assign uop   = disp_uop;
    assign is_br = uop.br.op == ooo_pkg::OP_BEQ;

    // branch format keeps its sources in other bits
    assign rs1 = is_br ? uop.br.rs1 : uop.alu.rs1;
    assign rs2 = is_br ? uop.br.rs2 : uop.alu.rs2;

    assign writes_rd = disp_valid && !flush && !is_br && uop.alu.op != ooo_pkg::OP_NOP;

    // busy source: ask the rob for the producer result
    assign rob_q1_tag = tag_tbl[rs1];
    assign rob_q2_tag = tag_tbl[rs2];
    assign src1_tag   = tag_tbl[rs1];
    assign src2_tag   = tag_tbl[rs2];
    assign src1_rdy   = !busy[rs1] || q1_ready;
    assign src2_rdy   = !busy[rs2] || q2_ready;
    assign src1_val   = busy[rs1] ? q1_val : regs[rs1];
    assign src2_val   = busy[rs2] ? q2_val : regs[rs2];

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
            for (int i = 0; i < ooo_pkg::ARCH_REGS; i++) begin
                regs[i]    <= '0;
                tag_tbl[i] <= '0;
            end
        end else begin
            if (commit_we) begin
                regs[commit_rd] <= commit_val;
                // a younger rename keeps the register busy
                if (tag_tbl[commit_rd] == commit_tag) begin
                    busy[commit_rd] <= 1'b0;
                end
            end
            if (flush) begin
                busy <= '0;
            end else if (writes_rd) begin
                busy[uop.alu.rd]    <= 1'b1;
                tag_tbl[uop.alu.rd] <= alloc_tag;
            end
        end
    end

endmodule

`default_nettype wire

// ==== reorder_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer (
    input  wire                            clk_in,
    input  wire                            rst_n,
    input  wire                            disp_valid,
    input  wire  [ooo_pkg::PC_W-1:0]       disp_pc,
    input  wire  [ooo_pkg::UOP_W-1:0]      disp_uop,
    input  wire  [ooo_pkg::ROB_TAG_W-1:0]  rob_q1_tag,
    input  wire  [ooo_pkg::ROB_TAG_W-1:0]  rob_q2_tag,
    input  wire                            cdb_valid,
    input  wire  [ooo_pkg::ROB_TAG_W-1:0]  cdb_tag,
    input  wire  [ooo_pkg::DATA_W-1:0]     cdb_val,
    input  wire                            cdb_taken,
    output logic [ooo_pkg::ROB_TAG_W-1:0]  alloc_tag,
    output logic                           q1_ready,
    output logic [ooo_pkg::DATA_W-1:0]     q1_val,
    output logic                           q2_ready,
    output logic [ooo_pkg::DATA_W-1:0]     q2_val,
    output logic                           commit_valid,
    output logic                           commit_we,
    output logic [ooo_pkg::REG_IDX_W-1:0]  commit_rd,
    output logic [ooo_pkg::DATA_W-1:0]     commit_val,
    output logic [ooo_pkg::ROB_TAG_W-1:0]  commit_tag,
    output logic                           credit_return,
    output logic                           flush,
    output logic [ooo_pkg::PC_W-1:0]       redirect_pc
);

    logic [ooo_pkg::ROB_DEPTH-1:0] busy;
    logic [ooo_pkg::ROB_DEPTH-1:0] done;
    logic [ooo_pkg::ROB_DEPTH-1:0] taken;
    logic [ooo_pkg::UOP_W-1:0]     uops [ooo_pkg::ROB_DEPTH];
    logic [ooo_pkg::PC_W-1:0]      pcs  [ooo_pkg::ROB_DEPTH];
    logic [ooo_pkg::DATA_W-1:0]    vals [ooo_pkg::ROB_DEPTH];
    logic [ooo_pkg::ROB_TAG_W-1:0] head;
    logic [ooo_pkg::ROB_TAG_W-1:0] tail;
    ooo_pkg::uop_t                 head_uop;
    logic                          retire;
    logic                          head_is_br;
    logic                          dispatch;

    assign dispatch  = disp_valid && !flush;
    assign alloc_tag = tail;

    // operand lookup, with a same-cycle bypass of the cdb
    assign q1_ready = done[rob_q1_tag] || (cdb_valid && cdb_tag == rob_q1_tag);
    assign q2_ready = done[rob_q2_tag] || (cdb_valid && cdb_tag == rob_q2_tag);
    assign q1_val   = done[rob_q1_tag] ? vals[rob_q1_tag] : cdb_val;
    assign q2_val   = done[rob_q2_tag] ? vals[rob_q2_tag] : cdb_val;

    assign head_uop   = uops[head];
    assign retire     = busy[head] && done[head];
    assign head_is_br = head_uop.br.op == ooo_pkg::OP_BEQ;

    assign commit_valid  = retire;
    assign credit_return = retire;
    assign commit_we     = retire && !head_is_br && head_uop.alu.op != ooo_pkg::OP_NOP;
    assign commit_rd     = head_uop.alu.rd;
    assign commit_val    = vals[head];
    assign commit_tag    = head;

    // actual direction from execute against the static guess in the word
    assign flush = retire && head_is_br && taken[head] != head_uop.br.pred_taken;

    // a branch entry holds its target in the value field
    assign redirect_pc = taken[head] ? vals[head] : pcs[head] + ooo_pkg::PC_W'(4);

    // depth is a power of two, pointers wrap on their own
    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
            done <= '0;
            head <= '0;
            tail <= '0;
        end else if (flush) begin
            busy <= '0;
            done <= '0;
            head <= '0;
            tail <= '0;
        end else begin
            if (cdb_valid) begin
                done[cdb_tag] <= 1'b1;
            end
            if (retire) begin
                busy[head] <= 1'b0;
                done[head] <= 1'b0;
                head       <= head + 1'b1;
            end
            if (dispatch) begin
                busy[tail] <= 1'b1;
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (dispatch) begin
            uops[tail] <= disp_uop;
            pcs[tail]  <= disp_pc;
        end
        if (cdb_valid) begin
            vals[cdb_tag]  <= cdb_val;
            taken[cdb_tag] <= cdb_taken;
        end
    end

endmodule

`default_nettype wire

// ==== issue_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_queue (
    input  wire                            clk_in,
    input  wire                            rst_n,
    input  wire                            disp_valid,
    input  wire  [ooo_pkg::PC_W-1:0]       disp_pc,
    input  wire  [ooo_pkg::UOP_W-1:0]      disp_uop,
    input  wire  [ooo_pkg::ROB_TAG_W-1:0]  alloc_tag,
    input  wire  [ooo_pkg::DATA_W-1:0]     src1_val,
    input  wire  [ooo_pkg::ROB_TAG_W-1:0]  src1_tag,
    input  wire                            src1_rdy,
    input  wire  [ooo_pkg::DATA_W-1:0]     src2_val,
    input  wire  [ooo_pkg::ROB_TAG_W-1:0]  src2_tag,
    input  wire                            src2_rdy,
    input  wire                            cdb_valid,
    input  wire  [ooo_pkg::ROB_TAG_W-1:0]  cdb_tag,
    input  wire  [ooo_pkg::DATA_W-1:0]     cdb_val,
    input  wire                            flush,
    output logic                           iss_valid,
    output logic [ooo_pkg::PC_W-1:0]       iss_pc,
    output logic [ooo_pkg::UOP_W-1:0]      iss_uop,
    output logic [ooo_pkg::ROB_TAG_W-1:0]  iss_tag,
    output logic [ooo_pkg::DATA_W-1:0]     iss_a,
    output logic [ooo_pkg::DATA_W-1:0]     iss_b
);

    logic [ooo_pkg::ROB_DEPTH-1:0] valid;
    logic [ooo_pkg::ROB_DEPTH-1:0] rdy1;
    logic [ooo_pkg::ROB_DEPTH-1:0] rdy2;
    logic [ooo_pkg::ROB_DEPTH-1:0] wake1;
    logic [ooo_pkg::ROB_DEPTH-1:0] wake2;
    logic [ooo_pkg::ROB_TAG_W-1:0] age  [ooo_pkg::ROB_DEPTH];
    logic [ooo_pkg::UOP_W-1:0]     uops [ooo_pkg::ROB_DEPTH];
    logic [ooo_pkg::PC_W-1:0]      pcs  [ooo_pkg::ROB_DEPTH];
    logic [ooo_pkg::ROB_TAG_W-1:0] tags [ooo_pkg::ROB_DEPTH];
    logic [ooo_pkg::ROB_TAG_W-1:0] tag1 [ooo_pkg::ROB_DEPTH];
    logic [ooo_pkg::ROB_TAG_W-1:0] tag2 [ooo_pkg::ROB_DEPTH];
    logic [ooo_pkg::DATA_W-1:0]    val1 [ooo_pkg::ROB_DEPTH];
    logic [ooo_pkg::DATA_W-1:0]    val2 [ooo_pkg::ROB_DEPTH];
    ooo_pkg::uop_t                 in_uop;
    logic                          insert;
    logic                          need1;
    logic                          need2;
    logic [ooo_pkg::ROB_TAG_W-1:0] free_idx;
    logic [ooo_pkg::ROB_TAG_W-1:0] sel_idx;

    assign in_uop = disp_uop;
    assign insert = disp_valid && !flush;
    // nop needs no operand, addi only the first
    assign need1  = in_uop.alu.op != ooo_pkg::OP_NOP;
    assign need2  = need1 && in_uop.alu.op != ooo_pkg::OP_ADDI;

    always_comb begin
        free_idx  = '0;
        sel_idx   = '0;
        iss_valid = 1'b0;
        for (int i = ooo_pkg::ROB_DEPTH - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                free_idx = ooo_pkg::ROB_TAG_W'(i);
            end
        end
        // oldest ready slot has the largest age
        for (int i = 0; i < ooo_pkg::ROB_DEPTH; i++) begin
            wake1[i] = valid[i] && !rdy1[i] && cdb_valid && tag1[i] == cdb_tag;
            wake2[i] = valid[i] && !rdy2[i] && cdb_valid && tag2[i] == cdb_tag;
            if (valid[i] && rdy1[i] && rdy2[i] && (!iss_valid || age[i] > age[sel_idx])) begin
                iss_valid = 1'b1;
                sel_idx   = ooo_pkg::ROB_TAG_W'(i);
            end
        end
    end

    assign iss_pc  = pcs[sel_idx];
    assign iss_uop = uops[sel_idx];
    assign iss_tag = tags[sel_idx];
    assign iss_a   = val1[sel_idx];
    assign iss_b   = val2[sel_idx];

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
            rdy1  <= '0;
            rdy2  <= '0;
            for (int i = 0; i < ooo_pkg::ROB_DEPTH; i++) begin
                age[i] <= '0;
            end
        end else if (flush) begin
            valid <= '0;
        end else begin
            for (int i = 0; i < ooo_pkg::ROB_DEPTH; i++) begin
                if (wake1[i]) rdy1[i] <= 1'b1;
                if (wake2[i]) rdy2[i] <= 1'b1;
                // waiting slots get older with each arrival
                if (insert && valid[i]) age[i] <= age[i] + 1'b1;
            end
            if (iss_valid) begin
                valid[sel_idx] <= 1'b0;
            end
            if (insert) begin
                valid[free_idx] <= 1'b1;
                rdy1[free_idx]  <= src1_rdy || !need1;
                rdy2[free_idx]  <= src2_rdy || !need2;
                age[free_idx]   <= '0;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        for (int i = 0; i < ooo_pkg::ROB_DEPTH; i++) begin
            if (wake1[i]) val1[i] <= cdb_val;
            if (wake2[i]) val2[i] <= cdb_val;
        end
        if (insert) begin
            uops[free_idx] <= disp_uop;
            pcs[free_idx]  <= disp_pc;
            tags[free_idx] <= alloc_tag;
            tag1[free_idx] <= src1_tag;
            tag2[free_idx] <= src2_tag;
            val1[free_idx] <= src1_val;
            val2[free_idx] <= src2_val;
        end
    end

endmodule

`default_nettype wire

// ==== exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  wire                            clk_in,
    input  wire                            rst_n,
    input  wire                            iss_valid,
    input  wire  [ooo_pkg::PC_W-1:0]       iss_pc,
    input  wire  [ooo_pkg::UOP_W-1:0]      iss_uop,
    input  wire  [ooo_pkg::ROB_TAG_W-1:0]  iss_tag,
    input  wire  [ooo_pkg::DATA_W-1:0]     iss_a,
    input  wire  [ooo_pkg::DATA_W-1:0]     iss_b,
    input  wire                            flush,
    output logic                           cdb_valid,
    output logic [ooo_pkg::ROB_TAG_W-1:0]  cdb_tag,
    output logic [ooo_pkg::DATA_W-1:0]     cdb_val,
    output logic                           cdb_taken
);

    ooo_pkg::uop_t              uop;
    logic [ooo_pkg::DATA_W-1:0] imm;
    logic [ooo_pkg::PC_W-1:0]   target;
    logic [ooo_pkg::DATA_W-1:0] result;
    logic                       is_br;

    assign uop    = iss_uop;
    assign is_br  = uop.br.op == ooo_pkg::OP_BEQ;
    assign imm    = {{(ooo_pkg::DATA_W - 4){uop.alu.imm4[3]}}, uop.alu.imm4};
    // word offset scaled to bytes
    assign target = iss_pc + {{(ooo_pkg::PC_W - 8){uop.br.offset[5]}}, uop.br.offset, 2'b00};

    always_comb begin
        case (uop.alu.op)
            ooo_pkg::OP_ADD:  result = iss_a + iss_b;
            ooo_pkg::OP_SUB:  result = iss_a - iss_b;
            ooo_pkg::OP_ADDI: result = iss_a + imm;
            ooo_pkg::OP_AND:  result = iss_a & iss_b;
            ooo_pkg::OP_XOR:  result = iss_a ^ iss_b;
            // rob takes the target for a redirect
            ooo_pkg::OP_BEQ:  result = target;
            default:          result = '0;
        endcase
    end

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= iss_valid && !flush;
        end
    end

    always_ff @(posedge clk_in) begin
        cdb_tag   <= iss_tag;
        cdb_val   <= result;
        cdb_taken <= is_br && iss_a == iss_b;
    end

endmodule

`default_nettype wire

// ==== ooo_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ooo_core_top (
    input  wire                            clk_in,
    input  wire                            rst_n,
    input  wire                            disp_valid,
    input  wire  [ooo_pkg::PC_W-1:0]       disp_pc,
    input  wire  [ooo_pkg::UOP_W-1:0]      disp_uop,
    output wire                            credit_return,
    output wire                            commit_valid,
    output wire                            commit_we,
    output wire  [ooo_pkg::REG_IDX_W-1:0]  commit_rd,
    output wire  [ooo_pkg::DATA_W-1:0]     commit_val,
    output wire                            flush,
    output wire  [ooo_pkg::PC_W-1:0]       redirect_pc
);

    // rename to rob lookup
    wire [ooo_pkg::ROB_TAG_W-1:0] rob_q1_tag;
    wire [ooo_pkg::ROB_TAG_W-1:0] rob_q2_tag;
    wire                          q1_ready;
    wire                          q2_ready;
    wire [ooo_pkg::DATA_W-1:0]    q1_val;
    wire [ooo_pkg::DATA_W-1:0]    q2_val;
    wire [ooo_pkg::ROB_TAG_W-1:0] alloc_tag;
    wire [ooo_pkg::ROB_TAG_W-1:0] commit_tag;

    // renamed sources into the queue
    wire [ooo_pkg::DATA_W-1:0]    src1_val;
    wire [ooo_pkg::DATA_W-1:0]    src2_val;
    wire [ooo_pkg::ROB_TAG_W-1:0] src1_tag;
    wire [ooo_pkg::ROB_TAG_W-1:0] src2_tag;
    wire                          src1_rdy;
    wire                          src2_rdy;

    wire                          iss_valid;
    wire [ooo_pkg::PC_W-1:0]      iss_pc;
    wire [ooo_pkg::UOP_W-1:0]     iss_uop;
    wire [ooo_pkg::ROB_TAG_W-1:0] iss_tag;
    wire [ooo_pkg::DATA_W-1:0]    iss_a;
    wire [ooo_pkg::DATA_W-1:0]    iss_b;

    wire                          cdb_valid;
    wire [ooo_pkg::ROB_TAG_W-1:0] cdb_tag;
    wire [ooo_pkg::DATA_W-1:0]    cdb_val;
    wire                          cdb_taken;

    rename_table u_rename (.*);

    reorder_buffer u_rob (.*);

    issue_queue u_iq (.*);

    exec_unit u_exec (.*);

endmodule

`default_nettype wire

// ==== ooo_core_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module ooo_core_props (
    input wire clk_in,
    input wire rst_n,
    input wire disp_valid,
    input wire flush,
    input wire commit_valid,
    input wire commit_we,
    input wire credit_return,
    input wire cdb_valid
);

    // entries allocated and not yet retired
    logic [3:0] outstanding;

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            outstanding <= '0;
        end else if (flush) begin
            outstanding <= '0;
        end else begin
            outstanding <= outstanding + 4'(disp_valid) - 4'(commit_valid);
        end
    end

    rob_depth_limit: assert property (@(posedge clk_in) disable iff (!rst_n)
        outstanding <= 4'(ooo_pkg::ROB_DEPTH))
        else $error("more entries outstanding than the reorder buffer holds");

    // the retiring branch is the last thing seen before every stage empties
    flush_with_commit: assert property (@(posedge clk_in) disable iff (!rst_n)
        flush |-> commit_valid ##1 !(commit_valid || cdb_valid))
        else $error("flush raised without a retiring branch or left work behind");

    we_with_commit: assert property (@(posedge clk_in) disable iff (!rst_n)
        commit_we |-> commit_valid && outstanding != '0)
        else $error("register write raised without an outstanding commit");

    quiet_in_reset: assert property (@(posedge clk_in)
        !rst_n |-> !(commit_valid || commit_we || credit_return || flush || cdb_valid))
        else $error("an output is active while in reset");

endmodule

bind reorder_buffer ooo_core_props u_props (.*);

`default_nettype wire

// ==== ooo_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ooo_core_tb;

    localparam int MAX_OPS   = 32;
    localparam int RUN_LIMIT = 2000;

    logic                           clk_in;
    logic                           rst_n;
    logic                           disp_valid;
    logic [ooo_pkg::PC_W-1:0]       disp_pc;
    logic [ooo_pkg::UOP_W-1:0]      disp_uop;
    wire                            credit_return;
    wire                            commit_valid;
    wire                            commit_we;
    wire  [ooo_pkg::REG_IDX_W-1:0]  commit_rd;
    wire  [ooo_pkg::DATA_W-1:0]     commit_val;
    wire                            flush;
    wire  [ooo_pkg::PC_W-1:0]       redirect_pc;

    // pc in the upper 32 bits, micro-op word in the lower 16
    logic [47:0]                program_mem [MAX_OPS];
    logic [ooo_pkg::DATA_W-1:0] arch_regs [ooo_pkg::ARCH_REGS];
    int                         in_flight [$];
    int                         num_ops;
    int                         next_idx;
    int                         credits;
    int                         errors;
    int                         timeouts;
    int                         cycles;
    int                         commits;
    int                         credit_pulses;
    int                         dispatched;
    int                         squashed;

    ooo_core_top UUT (.*);

    initial begin
        clk_in = 1'b0;
        forever begin
            #10 clk_in = ~clk_in;
        end
    end

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // offset counts words and is signed
    function automatic logic [31:0] branch_target(input logic [31:0] pc, input logic [15:0] word);
        return pc + {{24{word[5]}}, word[5:0], 2'b00};
    endfunction

    // num_ops when no vector holds that pc
    function automatic int index_of_pc(input logic [31:0] pc);
        int found;
        found = num_ops;
        for (int i = num_ops - 1; i >= 0; i--) begin
            if (program_mem[i][47:16] == pc) begin
                found = i;
            end
        end
        return found;
    endfunction

    task automatic dispatch_next();
        logic [31:0] pc;
        logic [15:0] word;
        pc         = program_mem[next_idx][47:16];
        word       = program_mem[next_idx][15:0];
        disp_valid = 1'b1;
        disp_pc    = pc;
        disp_uop   = word;
        in_flight.push_back(next_idx);
        credits--;
        dispatched++;
        // fetch follows the static guess of a branch
        if (word[15:13] == ooo_pkg::OP_BEQ && word[6]) begin
            next_idx = index_of_pc(branch_target(pc, word));
        end else begin
            next_idx++;
        end
    endtask

    // in-order reference for the op at the head
    task automatic retire_op();
        int          idx;
        logic [31:0] pc;
        logic [15:0] word;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] result;
        logic        taken;
        string       name;
        if (in_flight.size() == 0) begin
            errors++;
            $display("a commit arrived while no op was in flight");
            return;
        end
        idx  = in_flight.pop_front();
        pc   = program_mem[idx][47:16];
        word = program_mem[idx][15:0];
        name = $sformatf("pc %0h", pc);
        if (word[15:13] == ooo_pkg::OP_BEQ) begin
            taken = arch_regs[word[12:10]] == arch_regs[word[9:7]];
            compare_value({name, " commit_we"}, 0, commit_we);
            compare_value({name, " flush"}, taken != word[6], flush);
            if (taken != word[6]) begin
                compare_value({name, " redirect_pc"},
                              taken ? branch_target(pc, word) : pc + 4, redirect_pc);
            end
        end else begin
            a = arch_regs[word[9:7]];
            b = arch_regs[word[6:4]];
            case (word[15:13])
                ooo_pkg::OP_ADD:  result = a + b;
                ooo_pkg::OP_SUB:  result = a - b;
                ooo_pkg::OP_ADDI: result = a + {{28{word[3]}}, word[3:0]};
                ooo_pkg::OP_AND:  result = a & b;
                ooo_pkg::OP_XOR:  result = a ^ b;
                default:          result = '0;
            endcase
            compare_value({name, " flush"}, 0, flush);
            compare_value({name, " commit_we"}, word[15:13] != ooo_pkg::OP_NOP, commit_we);
            if (word[15:13] != ooo_pkg::OP_NOP) begin
                compare_value({name, " rd"}, word[12:10], commit_rd);
                compare_value({name, " value"}, result, commit_val);
                arch_regs[word[12:10]] = result;
            end
        end
    endtask

    initial begin
        void'($urandom(39));
        rst_n         = 1'b0;
        disp_valid    = 1'b0;
        disp_pc       = '0;
        disp_uop      = '0;
        errors        = 0;
        timeouts      = 0;
        cycles        = 0;
        commits       = 0;
        credit_pulses = 0;
        dispatched    = 0;
        squashed      = 0;
        num_ops       = 0;
        for (int i = 0; i < ooo_pkg::ARCH_REGS; i++) begin
            arch_regs[i] = '0;
        end
        // a pc of all ones marks the end of the program
        for (int i = 0; i < MAX_OPS; i++) begin
            program_mem[i] = {32'hffff_ffff, 16'(i)};
        end
        $readmemh("ooo_vectors.txt", program_mem);
        while (num_ops < MAX_OPS && program_mem[num_ops][47:16] != 32'hffff_ffff) begin
            num_ops++;
        end
        if (num_ops == 0) begin
            errors++;
            $display("no micro-ops were read from the vector file");
        end
        repeat (10) @(negedge clk_in);
        rst_n    = 1'b1;
        credits  = ooo_pkg::ROB_DEPTH;
        next_idx = 0;
        while ((next_idx < num_ops || in_flight.size() != 0) && cycles < RUN_LIMIT) begin
            @(negedge clk_in);
            cycles++;
            disp_valid = 1'b0;
            if (commit_valid) begin
                commits++;
                retire_op();
            end
            if (credit_return) begin
                credit_pulses++;
            end
            if (flush) begin
                // younger ops are squashed, restart from the corrected pc
                squashed += in_flight.size();
                in_flight.delete();
                credits  = ooo_pkg::ROB_DEPTH;
                next_idx = index_of_pc(redirect_pc);
            end else begin
                if (credits > 0 && next_idx < num_ops && $urandom_range(3) != 0) begin
                    dispatch_next();
                end
                // a returned credit is spent from the next cycle on
                if (credit_return) begin
                    credits++;
                end
            end
        end
        disp_valid = 1'b0;
        if (next_idx < num_ops || in_flight.size() != 0) begin
            timeouts++;
            $display("timeout: the program did not finish committing in %0d cycles", RUN_LIMIT);
        end
        compare_value("final credits", ooo_pkg::ROB_DEPTH, credits);
        compare_value("credit pulses", dispatched - squashed, credit_pulses);
        $display("commits %0d, check errors %0d, timeouts %0d", commits, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== ooo_vectors.txt ====
// one micro-op per line as a 48-bit hex value
// upper 32 bits are the pc, lower 16 bits are the micro-op word
00000000_6405
00000004_6883
00000008_2CA0
0000000C_5190
00000010_B630
00000014_99D0
00000018_7F8F
0000001C_0000
00000020_CA42
00000024_6487
00000028_C503
0000002C_D703
00000030_6481
00000034_2DB0
00000038_28B0
0000003C_C645
00000040_6D82
00000044_5D30
00000048_B390
0000004C_3640
00000050_7A84
00000054_2770

// ==== project.f ====
ooo_pkg.sv
rename_table.sv
reorder_buffer.sv
issue_queue.sv
exec_unit.sv
ooo_core_top.sv
ooo_core_props.sv
ooo_core_tb.sv
